// ==== project.f ====
+incdir+source
source/text_console_pkg.sv
source/display_timing.sv
source/text_buffer.sv
source/glyph_rom.sv
source/pixel_renderer.sv
source/text_console.sv
sim/text_console_sva.sv
sim/text_console_tb.sv

// ==== sim/text_console_tb.sv ====
// Text console testbench
// Types digit and command scan codes, rebuilds the pixel position from the
// sync outputs and compares a whole frame against local digit bitmaps

`default_nettype none

`include "text_console_config.svh"

module text_console_tb;

    import text_console_pkg::*;

    localparam int max_cycles = 2100000;    // five frames

    // left to right: 1 0, 2 replaced by 3, enter, 4, enter, stuck backspaces,
    // dropped code, blank non-digit, 5
    localparam keycode_t key_sequence [13] = '{
        8'h16, 8'h45, 8'h1E, `KEY_BACKSPACE, 8'h26, `KEY_ENTER, 8'h25,
        `KEY_ENTER, `KEY_BACKSPACE, `KEY_BACKSPACE, 8'h00, 8'h1C, 8'h2E
    };

    // cells the sequence leaves behind, rows 0..2 by columns 0..2
    localparam keycode_t typed_layout [3][3] = '{
        '{8'h16, 8'h45, 8'h26},
        '{8'h25, 8'h00, 8'h00},
        '{8'h1C, 8'h2E, 8'h00}
    };

    localparam logic [9:0] digit_0 [8] = '{
        10'b1111111100, 10'b1100001100, 10'b1100001100, 10'b1100001100,
        10'b1100001100, 10'b1100001100, 10'b1111111100, 10'b0000000000
    };
    localparam logic [9:0] digit_1 [8] = '{
        10'b0000001100, 10'b0000001100, 10'b0000001100, 10'b0000001100,
        10'b0000001100, 10'b0000001100, 10'b0000001100, 10'b0000000000
    };
    localparam logic [9:0] digit_3 [8] = '{
        10'b0011110000, 10'b1100001100, 10'b0000001100, 10'b0011110000,
        10'b0000001100, 10'b1100001100, 10'b0011110000, 10'b0000000000
    };
    localparam logic [9:0] digit_4 [8] = '{
        10'b0111100000, 10'b1101100000, 10'b1101100000, 10'b1101100000,
        10'b1101100000, 10'b1111111100, 10'b0001100000, 10'b0000000000
    };
    localparam logic [9:0] digit_5 [8] = '{
        10'b1111111100, 10'b1100000000, 10'b1100000000, 10'b1111111100,
        10'b0000001100, 10'b0000001100, 10'b1111110000, 10'b0000000000
    };

    logic     flag;
    logic     rst;
    keycode_t keycode;
    logic     key_valid;
    logic     vga_hs;
    logic     vga_vs;
    colour_t  vga_r;
    colour_t  vga_g;
    colour_t  vga_b;

    int       seed = 32'h377d_545a;
    int       errors = 0;
    int       cycles = 0;
    int       scan_x = 0;
    int       scan_y = 0;
    logic     locked = 1'b0;
    logic     check_on = 1'b0;
    logic     vs_prev = 1'b1;

    text_console DUT (
        .flag      (flag),
        .rst       (rst),
        .keycode   (keycode),
        .key_valid (key_valid),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial flag = 1'b0;
    always #50 flag = ~flag;

    ////////////////////////////////////////////////////////////////////////////
    // reference screen
    ////////////////////////////////////////////////////////////////////////////
    function automatic keycode_t expected_code(input int row, input int col);
        if (row < 3 && col < 3)
            return typed_layout[row][col];
        return 8'h00;
    endfunction

    function automatic logic [9:0] glyph_row(input keycode_t code, input int line);
        case (code)
            8'h45:   return digit_0[line];
            8'h16:   return digit_1[line];
            8'h26:   return digit_3[line];
            8'h25:   return digit_4[line];
            8'h2E:   return digit_5[line];
            default: return 10'b0;          // non-digits show blank
        endcase
    endfunction

    function automatic string test_name(input int px, input int py);
        if (px >= `H_VISIBLE || py >= `V_VISIBLE)
            return "blanking";
        case (py / `CELL_H)
            0:       return "render_backspace";
            1:       return "enter";
            2:       return "ignored_code";
            default: return "blank_cells";
        endcase
    endfunction

    task automatic check_pixel;
        colour_t    exp;
        logic [9:0] bits;
        exp = 4'h0;
        if (scan_x < `H_VISIBLE && scan_y < `V_VISIBLE)
        begin
            bits = glyph_row(expected_code(scan_y / `CELL_H, scan_x / `CELL_W),
                             scan_y % `CELL_H);
            exp  = bits[`CELL_W - 1 - scan_x % `CELL_W] ? 4'hF : 4'h0;
        end
        if (check_on || scan_x >= `H_VISIBLE || scan_y >= `V_VISIBLE)
        begin
            assert ({vga_r, vga_g, vga_b} == {3{exp}})
            else
            begin
                $display("ERR %s at (%0d,%0d) expected %h actual %h",
                         test_name(scan_x, scan_y), scan_x, scan_y,
                         {3{exp}}, {vga_r, vga_g, vga_b});
                errors++;
            end
        end
    endtask

    // screen position rebuilt from vsync, falling edge is line 490 pixel 0
    always @(negedge flag)
    begin
        if (locked)
        begin
            scan_x = scan_x + 1;
            if (scan_x == `H_TOTAL)
            begin
                scan_x = 0;
                scan_y = (scan_y + 1) % `V_TOTAL;
            end
        end
        else if (!rst && vs_prev && !vga_vs)
        begin
            locked = 1'b1;
            scan_x = 0;
            scan_y = `V_SYNC_START;
        end
        vs_prev = vga_vs;
        if (locked)
            check_pixel();
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic press_key(input keycode_t code);
        int gap;
        gap = 1 + ($unsigned($random(seed)) % 16);
        repeat (gap) @(posedge flag);
        keycode   <= code;
        key_valid <= 1'b1;
        @(posedge flag);
        key_valid <= 1'b0;
        keycode   <= 8'h00;
    endtask

    always @(posedge flag)
    begin
        cycles <= cycles + 1;
        if (cycles == max_cycles)
        begin
            $display("timeout: the checked frame did not finish within %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        rst       = 1'b1;
        keycode   = 8'h00;
        key_valid = 1'b0;
        repeat (10) @(posedge flag);
        rst <= 1'b0;
        repeat (`TEXT_COLS * `TEXT_ROWS + 100) @(posedge flag);    // clear sweep
        foreach (key_sequence[i])
        begin
            press_key(key_sequence[i]);
        end
        wait (locked);
        check_on = 1'b1;                    // next visible area is after all keys
        wait (scan_y == 0);
        wait (scan_y == `V_SYNC_END + 1);   // past the second vsync pulse
        repeat (2) @(posedge flag);
        $display("checks done: %0d testbench errors, %0d assertion errors",
                 errors, DUT.sva_checks.sva_errors);
        if (errors == 0 && DUT.sva_checks.sva_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/text_console_sva.sv ====
// Text console assertions
// Sync period and pulse width, idle outputs around reset, black during
// blanking and legal colour levels

`default_nettype none

`include "text_console_config.svh"

module text_console_sva
(
    input logic                      flag,
    input logic                      rst,
    input logic                      video_on,
    input logic                      vga_hs,
    input logic                      vga_vs,
    input text_console_pkg::colour_t vga_r,
    input text_console_pkg::colour_t vga_g,
    input text_console_pkg::colour_t vga_b
);

    int   sva_errors = 0;
    int   hs_period;
    int   hs_low;
    int   vs_period;
    int   vs_low;
    logic hs_prev;
    logic vs_prev;
    logic hs_seen;
    logic vs_seen;
    logic hs_fall;
    logic vs_fall;

    assign hs_fall = hs_prev && !vga_hs;
    assign vs_fall = vs_prev && !vga_vs;

    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            hs_prev   <= 1'b1;
            vs_prev   <= 1'b1;
            hs_seen   <= 1'b0;
            vs_seen   <= 1'b0;
            hs_period <= 0;
            vs_period <= 0;
            hs_low    <= 0;
            vs_low    <= 0;
        end
        else
        begin
            hs_prev   <= vga_hs;
            vs_prev   <= vga_vs;
            hs_seen   <= hs_seen || hs_fall;
            vs_seen   <= vs_seen || vs_fall;
            hs_period <= hs_fall ? 1 : hs_period + 1;   // cycles since last fall
            vs_period <= vs_fall ? 1 : vs_period + 1;
            hs_low    <= vga_hs ? 0 : hs_low + 1;
            vs_low    <= vga_vs ? 0 : vs_low + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////////////////////
    idle_in_reset: assert property (@(posedge flag)
        rst |=> (vga_hs && vga_vs && vga_r == '0 && vga_g == '0 && vga_b == '0))
        else begin $error("outputs not idle around reset"); sva_errors++; end

    hs_period_ok: assert property (@(posedge flag) disable iff (rst)
        (hs_fall && hs_seen) |-> hs_period == `H_TOTAL)
        else begin $error("hsync period wrong: %0d", hs_period); sva_errors++; end

    hs_width_ok: assert property (@(posedge flag) disable iff (rst)
        (!hs_prev && vga_hs) |-> hs_low == `H_SYNC_END - `H_SYNC_START + 1)
        else begin $error("hsync pulse width wrong: %0d", hs_low); sva_errors++; end

    vs_period_ok: assert property (@(posedge flag) disable iff (rst)
        (vs_fall && vs_seen) |-> vs_period == `H_TOTAL * `V_TOTAL)
        else begin $error("vsync period wrong: %0d", vs_period); sva_errors++; end

    vs_width_ok: assert property (@(posedge flag) disable iff (rst)
        (!vs_prev && vga_vs) |-> vs_low == (`V_SYNC_END - `V_SYNC_START + 1) * `H_TOTAL)
        else begin $error("vsync pulse width wrong: %0d", vs_low); sva_errors++; end

    // colours land three cycles after the counters
    blank_black: assert property (@(posedge flag) disable iff (rst)
        !video_on |-> ##3 (vga_r == '0 && vga_g == '0 && vga_b == '0))
        else begin $error("colour during blanking"); sva_errors++; end

    levels_ok: assert property (@(posedge flag) disable iff (rst)
        vga_r == vga_g && vga_g == vga_b && (vga_r == 4'h0 || vga_r == 4'hF))
        else begin $error("colour level not black or white"); sva_errors++; end

endmodule

bind text_console text_console_sva sva_checks (
    .flag     (flag),
    .rst      (rst),
    .video_on (video_on),
    .vga_hs   (vga_hs),
    .vga_vs   (vga_vs),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b)
);

`default_nettype wire

// ==== source/text_console.sv ====
// VGA text console
// Shows typed PS/2 scan codes on a 64x60 character grid at 640x480

`default_nettype none

module text_console
(
    input  logic                        flag,
    input  logic                        rst,
    input  text_console_pkg::keycode_t  keycode,
    input  logic                        key_valid,
    output logic                        vga_hs,
    output logic                        vga_vs,
    output text_console_pkg::colour_t   vga_r,
    output text_console_pkg::colour_t   vga_g,
    output text_console_pkg::colour_t   vga_b
);

    import text_console_pkg::*;

    pixel_x_t    pixel_x;
    pixel_y_t    pixel_y;
    logic        video_on;
    logic        hsync;
    logic        vsync;
    keycode_t    char_code;
    glyph_line_t glyph_line;
    glyph_bits_t glyph_bits;

    display_timing u_timing (
        .flag       (flag),
        .rst        (rst),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .video_on   (video_on),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    text_buffer u_buffer (
        .flag       (flag),
        .rst        (rst),
        .keycode    (keycode),
        .key_valid  (key_valid),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .char_code  (char_code)
    );

    glyph_rom u_rom (
        .flag       (flag),
        .char_code  (char_code),
        .glyph_line (glyph_line),
        .glyph_bits (glyph_bits)
    );

    pixel_renderer u_renderer (
        .flag       (flag),
        .rst        (rst),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .video_on   (video_on),
        .hsync      (hsync),
        .vsync      (vsync),
        .glyph_bits (glyph_bits),
        .glyph_line (glyph_line),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

`default_nettype wire

// ==== source/pixel_renderer.sv ====
// Pixel renderer
// Carries blanking, sync and glyph position alongside the buffer and ROM
// reads, then drives white for set glyph bits and black elsewhere

`default_nettype none

`include "text_console_config.svh"

module pixel_renderer
(
    input  logic                          flag,
    input  logic                          rst,
    input  text_console_pkg::pixel_x_t    pixel_x,
    input  text_console_pkg::pixel_y_t    pixel_y,
    input  logic                          video_on,
    input  logic                          hsync,
    input  logic                          vsync,
    input  text_console_pkg::glyph_bits_t glyph_bits,
    output text_console_pkg::glyph_line_t glyph_line,
    output logic                          vga_hs,
    output logic                          vga_vs,
    output text_console_pkg::colour_t     vga_r,
    output text_console_pkg::colour_t     vga_g,
    output text_console_pkg::colour_t     vga_b
);

    import text_console_pkg::*;

    logic [3:0] glyph_col;
    logic [3:0] col_s1;
    logic [3:0] col_s2;
    logic       video_s1;
    logic       video_s2;
    logic       hsync_s1;
    logic       hsync_s2;
    logic       vsync_s1;
    logic       vsync_s2;
    logic       pixel_on;
    colour_t    level;

    assign glyph_col = 4'(pixel_x % pixel_x_t'(`CELL_W));

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 matches char_code, stage 2 matches glyph_bits
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            video_s1 <= 1'b0;
            video_s2 <= 1'b0;
            hsync_s1 <= 1'b1;
            hsync_s2 <= 1'b1;
            vsync_s1 <= 1'b1;
            vsync_s2 <= 1'b1;
        end
        else
        begin
            video_s1 <= video_on;
            video_s2 <= video_s1;
            hsync_s1 <= hsync;
            hsync_s2 <= hsync_s1;
            vsync_s1 <= vsync;
            vsync_s2 <= vsync_s1;
        end
    end

    always_ff @(posedge flag)
    begin
        glyph_line <= glyph_line_t'(pixel_y % pixel_y_t'(`CELL_H));    // to the rom
        col_s1     <= glyph_col;
        col_s2     <= col_s1;
    end

    // leftmost pixel sits in the top bit
    assign pixel_on = video_s2 && glyph_bits[`CELL_W - 1 - col_s2];
    assign level    = pixel_on ? 4'hF : 4'h0;

    // stage 3 outputs
    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
        end
        else
        begin
            vga_hs <= hsync_s2;
            vga_vs <= vsync_s2;
            vga_r  <= level;
            vga_g  <= level;
            vga_b  <= level;
        end
    end

endmodule

`default_nettype wire

// ==== source/glyph_rom.sv ====
// Glyph ROM
// Registered 8-line by 10-pixel bitmaps for the digit scan codes; every
// other code reads as a blank cell

`default_nettype none

module glyph_rom
(
    input  logic                          flag,
    input  text_console_pkg::keycode_t    char_code,
    input  text_console_pkg::glyph_line_t glyph_line,
    output text_console_pkg::glyph_bits_t glyph_bits
);

    import text_console_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // digit bitmaps, line 0 at the top
    ////////////////////////////////////////////////////////////////////////////
    localparam glyph_bits_t glyph_0 [8] = '{
        10'b1111111100, 10'b1100001100, 10'b1100001100, 10'b1100001100,
        10'b1100001100, 10'b1100001100, 10'b1111111100, 10'b0000000000
    };
    localparam glyph_bits_t glyph_1 [8] = '{
        10'b0000001100, 10'b0000001100, 10'b0000001100, 10'b0000001100,
        10'b0000001100, 10'b0000001100, 10'b0000001100, 10'b0000000000
    };
    localparam glyph_bits_t glyph_2 [8] = '{
        10'b0011110000, 10'b1100001100, 10'b0000011000, 10'b0000110000,
        10'b0001100000, 10'b0011000000, 10'b1111111100, 10'b0000000000
    };
    localparam glyph_bits_t glyph_3 [8] = '{
        10'b0011110000, 10'b1100001100, 10'b0000001100, 10'b0011110000,
        10'b0000001100, 10'b1100001100, 10'b0011110000, 10'b0000000000
    };
    localparam glyph_bits_t glyph_4 [8] = '{
        10'b0111100000, 10'b1101100000, 10'b1101100000, 10'b1101100000,
        10'b1101100000, 10'b1111111100, 10'b0001100000, 10'b0000000000
    };
    localparam glyph_bits_t glyph_5 [8] = '{
        10'b1111111100, 10'b1100000000, 10'b1100000000, 10'b1111111100,
        10'b0000001100, 10'b0000001100, 10'b1111110000, 10'b0000000000
    };
    localparam glyph_bits_t glyph_6 [8] = '{
        10'b1111111100, 10'b1100000000, 10'b1100000000, 10'b1111111100,
        10'b1100001100, 10'b1100001100, 10'b1111110000, 10'b0000000000
    };
    localparam glyph_bits_t glyph_7 [8] = '{
        10'b1111111100, 10'b0000001100, 10'b0000001100, 10'b0000001100,
        10'b0000001100, 10'b0000001100, 10'b0000001100, 10'b0000000000
    };
    localparam glyph_bits_t glyph_8 [8] = '{
        10'b1111111100, 10'b1100001100, 10'b1100001100, 10'b1111111100,
        10'b1100001100, 10'b1100001100, 10'b1111111100, 10'b0000000000
    };
    localparam glyph_bits_t glyph_9 [8] = '{
        10'b1111111100, 10'b1100001100, 10'b1100001100, 10'b1111111100,
        10'b0000001100, 10'b0000001100, 10'b1111111100, 10'b0000000000
    };

    ////////////////////////////////////////////////////////////////////////////
    // lookup by scan code
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge flag)
    begin
        case (char_code)
            8'h45:   glyph_bits <= glyph_0[glyph_line];
            8'h16:   glyph_bits <= glyph_1[glyph_line];
            8'h1E:   glyph_bits <= glyph_2[glyph_line];
            8'h26:   glyph_bits <= glyph_3[glyph_line];
            8'h25:   glyph_bits <= glyph_4[glyph_line];
            8'h2E:   glyph_bits <= glyph_5[glyph_line];
            8'h36:   glyph_bits <= glyph_6[glyph_line];
            8'h3D:   glyph_bits <= glyph_7[glyph_line];
            8'h3E:   glyph_bits <= glyph_8[glyph_line];
            8'h46:   glyph_bits <= glyph_9[glyph_line];
            default: glyph_bits <= '0;                      // blank cell
        endcase
    end

endmodule

`default_nettype wire

// ==== source/text_buffer.sv ====
// Text buffer
// Scan-code store for the 60x64 grid with typing cursor, per-row saved column
// and a registered read port addressed by the current pixel

`default_nettype none

`include "text_console_config.svh"

module text_buffer
(
    input  logic                         flag,
    input  logic                         rst,
    input  text_console_pkg::keycode_t   keycode,
    input  logic                         key_valid,
    input  text_console_pkg::pixel_x_t   pixel_x,
    input  text_console_pkg::pixel_y_t   pixel_y,
    output text_console_pkg::keycode_t   char_code
);

    import text_console_pkg::*;

    localparam int cell_count = `TEXT_ROWS * `TEXT_COLS;

    keycode_t    store [cell_count];
    text_col_t   saved_col [`TEXT_ROWS];
    text_row_t   cur_row;
    text_col_t   cur_col;

    logic        clearing;
    logic [11:0] clear_addr;

    logic        key_seen;
    logic        is_backspace;
    logic        is_enter;
    logic        key_write;

    text_row_t   read_row;
    text_col_t   read_col;
    logic        in_grid;

    ////////////////////////////////////////////////////////////////////////////
    // key decode
    ////////////////////////////////////////////////////////////////////////////
    assign key_seen     = key_valid && (keycode != '0);      // code 0 is dropped
    assign is_backspace = key_seen && (keycode == `KEY_BACKSPACE);
    assign is_enter     = key_seen && (keycode == `KEY_ENTER);
    assign key_write    = key_seen && !is_backspace && !is_enter;

    // cursor and saved columns
    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            cur_row <= '0;
            cur_col <= '0;
            for (int i = 0; i < `TEXT_ROWS; i++)
            begin
                saved_col[i] <= '0;
            end
        end
        else if (is_backspace)
        begin
            if (cur_col != '0)
            begin
                cur_col <= cur_col - 1'b1;
            end
        end
        else if (is_enter)
        begin
            saved_col[cur_row] <= cur_col;
            if (cur_row != text_row_t'(`TEXT_ROWS - 1))     // last row keeps its column
            begin
                cur_row <= cur_row + 1'b1;
                cur_col <= saved_col[cur_row + 1'b1];
            end
        end
        else if (key_write)
        begin
            if (cur_col != text_col_t'(`TEXT_COLS - 1))     // last cell gets overwritten
            begin
                cur_col <= cur_col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // store write port, shared by key writes and the clear sweep
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end
        else if (clearing && !key_write)                    // sweep waits on a key write
        begin
            if (clear_addr == 12'(cell_count - 1))
            begin
                clearing <= 1'b0;
            end
            else
            begin
                clear_addr <= clear_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge flag)
    begin
        if (key_write)
        begin
            store[{cur_row, cur_col}] <= keycode;
        end
        else if (clearing)
        begin
            store[clear_addr] <= '0;
        end
    end

    // read port, cell under the pixel
    assign read_row = text_row_t'(pixel_y / pixel_y_t'(`CELL_H));
    assign read_col = text_col_t'(pixel_x / pixel_x_t'(`CELL_W));
    assign in_grid  = (pixel_x < `H_VISIBLE) && (pixel_y < `V_VISIBLE);

    always_ff @(posedge flag)
    begin
        char_code <= in_grid ? store[{read_row, read_col}] : '0;
    end

endmodule

`default_nettype wire

// ==== source/display_timing.sv ====
// Display timing generator
// Pixel and line counters for 640x480, with registered active-low syncs
// and visible-area flag that line up with the counters

`default_nettype none

`include "text_console_config.svh"

module display_timing
(
    input  logic                         flag,
    input  logic                         rst,
    output text_console_pkg::pixel_x_t   pixel_x,
    output text_console_pkg::pixel_y_t   pixel_y,
    output logic                         video_on,
    output logic                         hsync,
    output logic                         vsync
);

    import text_console_pkg::*;

    pixel_x_t next_x;
    pixel_y_t next_y;
    logic     line_end;
    logic     frame_end;

    ////////////////////////////////////////////////////////////////////////////
    // next counter values
    ////////////////////////////////////////////////////////////////////////////
    assign line_end  = (pixel_x == pixel_x_t'(`H_TOTAL - 1));
    assign frame_end = (pixel_y == pixel_y_t'(`V_TOTAL - 1));

    assign next_x = line_end ? '0 : pixel_x + 1'b1;

    always_comb
    begin
        next_y = pixel_y;
        if (line_end)
        begin
            next_y = frame_end ? '0 : pixel_y + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // counters and flags, decoded from next values so no lag
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge flag)
    begin
        if (rst)
        begin
            pixel_x  <= '0;
            pixel_y  <= '0;
            video_on <= 1'b1;           // pixel 0, line 0 is visible
            hsync    <= 1'b1;
            vsync    <= 1'b1;
        end
        else
        begin
            pixel_x  <= next_x;
            pixel_y  <= next_y;
            video_on <= (next_x < `H_VISIBLE) && (next_y < `V_VISIBLE);
            hsync    <= !((next_x >= `H_SYNC_START) && (next_x <= `H_SYNC_END));
            vsync    <= !((next_y >= `V_SYNC_START) && (next_y <= `V_SYNC_END));
        end
    end

endmodule

`default_nettype wire

// ==== source/text_console_pkg.sv ====
// Text console types
// Shared widths for scan codes, screen coordinates, grid positions and colour

`default_nettype none

package text_console_pkg;

    typedef logic [7:0] keycode_t;      // ps/2 scan code

    typedef logic [9:0] pixel_x_t;      // 0..799
    typedef logic [9:0] pixel_y_t;      // 0..524

    typedef logic [5:0] text_col_t;     // 0..63
    typedef logic [5:0] text_row_t;     // 0..59

    typedef logic [2:0] glyph_line_t;   // line inside a cell

    // one glyph line, leftmost pixel in bit 9
    typedef logic [9:0] glyph_bits_t;

    typedef logic [3:0] colour_t;       // one vga channel

endpackage

`default_nettype wire

// ==== source/text_console_config.svh ====
// Text console configuration
// 640x480 display timing, character grid and cell size, command scan codes

`ifndef TEXT_CONSOLE_CONFIG_SVH
`define TEXT_CONSOLE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// display timing, one pixel per clock
////////////////////////////////////////////////////////////////////////////
`define H_VISIBLE     640
`define H_SYNC_START  656   // hsync low from here
`define H_SYNC_END    751   // through here
`define H_TOTAL       800

`define V_VISIBLE     480
`define V_SYNC_START  490   // vsync low for two lines
`define V_SYNC_END    491
`define V_TOTAL       525

////////////////////////////////////////////////////////////////////////////
// character grid
////////////////////////////////////////////////////////////////////////////
`define CELL_W        10    // pixels per cell
`define CELL_H        8     // lines per cell
`define TEXT_COLS     64
`define TEXT_ROWS     60

`define KEY_BACKSPACE 8'h66
`define KEY_ENTER     8'h5A

`endif
